// File: sim.f
+incdir+source
source/net_types_pkg.sv
source/net_stat_pkg.sv
source/net_ctrl_if.sv
source/reg_slice.sv
source/network_slice_array.sv
source/arp_responder.sv
source/network_ctrl_top.sv
bench/clock_gen.sv
bench/network_ctrl_sva.sv
bench/network_ctrl_tb.sv

// File: Bender.yml
package:
  name: network_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/net_types_pkg.sv
      - source/net_stat_pkg.sv
      - source/net_ctrl_if.sv
      - source/reg_slice.sv
      - source/network_slice_array.sv
      - source/arp_responder.sv
      - source/network_ctrl_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - bench/clock_gen.sv
      - bench/network_ctrl_sva.sv
      - bench/network_ctrl_tb.sv

// File: bench/network_ctrl_tb.sv
/*
 * Table-driven testbench for the network control path.
 * Runs lookups, latency, random back-pressure and statistics tests.
 */
`timescale 1ns/1ps
`include "net_config.svh"
`default_nettype none

module network_ctrl_tb
  import net_types_pkg::*, net_stat_pkg::*;
();

  localparam int N = `NET_N_STAGES;
  localparam int LAT = 2 * N + 1;
  localparam int TABLE_LEN = 12;
  localparam int WATCHDOG_CYCLES = TABLE_LEN * (2 * N + 10) + 200;

  logic aclk, reset;
  logic arp_req_valid, arp_req_ready, arp_rsp_valid, arp_rsp_ready;
  logic set_ip_valid, set_ip_ready, set_board_valid, set_board_ready;
  arp_request_t arp_req_data;
  arp_reply_t arp_rsp_data;
  ip_addr_t set_ip_data;
  board_num_t set_board_data;
  net_stat_t net_stats;

  // Config to program, lookup target, expected answer
  typedef struct packed {
    logic [31:0] ip;
    logic [7:0]  board;
    logic [31:0] target;
    logic        hit;
    logic [47:0] mac;
  } lookup_entry_t;

  lookup_entry_t lookup_table [TABLE_LEN];
  arp_reply_t expect_q [$];
  int accept_q [$];
  ip_addr_t cur_ip;
  board_num_t cur_board;
  logic [31:0] lcg_state = 32'h5019;
  int cycle_count = 0;
  int error_count = 0;
  int test_errors = 0;
  int tests_run = 0;
  int sva_seen = 0;
  int sent_requests = 0;
  int sent_hits = 0;
  int sent_misses = 0;

  clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) clock_gen_inst (.aclk(aclk), .reset(reset));

  network_ctrl_top network_ctrl_top_inst (
    .aclk(aclk), .reset(reset),
    .arp_req_valid(arp_req_valid), .arp_req_ready(arp_req_ready),
    .arp_req_data(arp_req_data),
    .arp_rsp_valid(arp_rsp_valid), .arp_rsp_ready(arp_rsp_ready),
    .arp_rsp_data(arp_rsp_data),
    .set_ip_valid(set_ip_valid), .set_ip_ready(set_ip_ready), .set_ip_data(set_ip_data),
    .set_board_valid(set_board_valid), .set_board_ready(set_board_ready),
    .set_board_data(set_board_data),
    .net_stats(net_stats)
  );

  bind network_ctrl_top network_ctrl_sva network_ctrl_sva_inst (.*);

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
  end

  // Hard stop if traffic never drains
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("Watchdog expired after %0d cycles, traffic did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Same top 24 bits means a hit
  function automatic arp_reply_t subnet_reply(input logic [31:0] ip, input logic [7:0] board,
                                              input logic [31:0] target);
    arp_reply_t r;
    r.target.word = target;
    r.hit = (target >> 8) == (ip >> 8);
    r.mac = r.hit ? {`NET_MAC_OUI, board, target[15:0]} : 48'h0;
    return r;
  endfunction

  task automatic fill_table();
    lookup_table[0]  = '{32'hc0a80105, 8'h07, 32'hc0a8010a, 1'b1, 48'h021a4e07010a};
    lookup_table[1]  = '{32'hc0a80105, 8'h07, 32'hc0a801fe, 1'b1, 48'h021a4e0701fe};
    lookup_table[2]  = '{32'hc0a80105, 8'h07, 32'hc0a80201, 1'b0, 48'h0};
    lookup_table[3]  = '{32'hc0a80105, 8'h07, 32'h0a000001, 1'b0, 48'h0};
    // Board rewrite within the same subnet
    lookup_table[4]  = '{32'hc0a80105, 8'h2c, 32'hc0a80133, 1'b1, 48'h021a4e2c0133};
    lookup_table[5]  = '{32'hc0a80105, 8'h2c, 32'hc0a80005, 1'b0, 48'h0};
    lookup_table[6]  = '{32'h0a141e28, 8'h2c, 32'h0a141e01, 1'b1, 48'h021a4e2c1e01};
    lookup_table[7]  = '{32'h0a141e28, 8'h2c, 32'h0a141f01, 1'b0, 48'h0};
    lookup_table[8]  = '{32'h0a141e28, 8'h91, 32'h0a141eff, 1'b1, 48'h021a4e911eff};
    lookup_table[9]  = '{32'h0a141e28, 8'h91, 32'h0b141e28, 1'b0, 48'h0};
    lookup_table[10] = '{32'h0a141e28, 8'h91, 32'h0a141e28, 1'b1, 48'h021a4e911e28};
    lookup_table[11] = '{32'h0a141e28, 8'h91, 32'h8a141e28, 1'b0, 48'h0};
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
    error_count++;
    test_errors++;
  endtask

  // Assertion failures since the previous test count against this one
  task automatic end_test(input string name);
    int sva_new;
    sva_new = network_ctrl_top_inst.network_ctrl_sva_inst.failures - sva_seen;
    if (sva_new > 0) begin
      $display("Error at %0t: %0d handshake assertion failures in this test",
               $time, sva_new);
      error_count += sva_new;
      test_errors += sva_new;
      sva_seen += sva_new;
    end
    tests_run++;
    $display("Test %0d %s: %s (%0d errors)", tests_run, name,
             (test_errors == 0) ? "pass" : "FAIL", test_errors);
    test_errors = 0;
  endtask

  // Write both settings at once and let them reach the responder
  task automatic write_config(input logic [31:0] ip, input logic [7:0] board);
    bit ip_taken;
    bit board_taken;
    set_ip_valid = 1'b1;
    set_ip_data.word = ip;
    set_board_valid = 1'b1;
    set_board_data = board;
    while (set_ip_valid || set_board_valid) begin
      ip_taken = set_ip_valid && set_ip_ready;
      board_taken = set_board_valid && set_board_ready;
      @(negedge aclk);
      if (ip_taken) begin
        set_ip_valid = 1'b0;
      end
      if (board_taken) begin
        set_board_valid = 1'b0;
      end
    end
    cur_ip.word = ip;
    cur_board = board;
    repeat (N + 2) @(negedge aclk);
  endtask

  // Reply is taken at the coming rising edge
  task automatic check_reply(input bit check_latency);
    arp_reply_t exp;
    int acc;
    if (expect_q.size() == 0) begin
      $display("Error at %0t: reply arrived with no request outstanding", $time);
      error_count++;
      test_errors++;
      return;
    end
    exp = expect_q.pop_front();
    acc = accept_q.pop_front();
    if (arp_rsp_data.hit !== exp.hit) begin
      report_mismatch("arp_rsp_data.hit", arp_rsp_data.hit, exp.hit);
    end
    if (arp_rsp_data.mac !== exp.mac) begin
      report_mismatch("arp_rsp_data.mac", arp_rsp_data.mac, exp.mac);
    end
    if (arp_rsp_data.target.word !== exp.target.word) begin
      report_mismatch("arp_rsp_data.target", arp_rsp_data.target.word, exp.target.word);
    end
    if (check_latency && (cycle_count - acc) != LAT) begin
      report_mismatch("reply latency", cycle_count - acc, LAT);
    end
  endtask

  // Sends table targets and drains replies one falling edge at a time
  task automatic run_traffic(input int first, input int count, input bit use_table,
                             input bit random_ready, input bit check_latency);
    int issued;
    int accepted;
    bit req_taken;
    arp_reply_t pending;
    issued = 0;
    accepted = 0;
    req_taken = 1'b0;
    while (accepted < count || expect_q.size() > 0) begin
      if (req_taken) begin
        arp_req_valid = 1'b0;
      end
      if (!arp_req_valid && issued < count) begin
        arp_req_valid = 1'b1;
        arp_req_data.target.word = lookup_table[first + issued].target;
        if (use_table) begin
          pending.hit = lookup_table[first + issued].hit;
          pending.mac = lookup_table[first + issued].mac;
          pending.target.word = lookup_table[first + issued].target;
        end else begin
          pending = subnet_reply(cur_ip.word, cur_board, lookup_table[first + issued].target);
        end
        issued++;
      end
      // Reply ready held high leaves no reason to stall a request
      if (check_latency && arp_req_valid && arp_req_ready !== 1'b1) begin
        report_mismatch("arp_req_ready", arp_req_ready, 1'b1);
      end
      req_taken = arp_req_valid && arp_req_ready;
      if (req_taken) begin
        expect_q.push_back(pending);
        accept_q.push_back(cycle_count);
        accepted++;
        sent_requests++;
        if (pending.hit) begin
          sent_hits++;
        end else begin
          sent_misses++;
        end
      end
      if (random_ready) begin
        lcg_state = lcg_next(lcg_state);
        arp_rsp_ready = lcg_state[16];
      end else begin
        arp_rsp_ready = 1'b1;
      end
      if (arp_rsp_valid && arp_rsp_ready) begin
        check_reply(check_latency);
      end
      @(negedge aclk);
    end
    arp_req_valid = 1'b0;
    arp_rsp_ready = 1'b1;
  endtask

  initial begin
    arp_req_valid = 1'b0;
    arp_req_data = '0;
    arp_rsp_ready = 1'b1;
    set_ip_valid = 1'b0;
    set_ip_data = '0;
    set_board_valid = 1'b0;
    set_board_data = '0;
    cur_ip = '0;
    cur_board = '0;
    fill_table();

    // Reset release, then one idle cycle
    @(negedge reset);
    @(negedge aclk);

    // Idle state out of reset
    if (arp_rsp_valid !== 1'b0) report_mismatch("arp_rsp_valid", arp_rsp_valid, 1'b0);
    if (net_stats !== '0) report_mismatch("net_stats", net_stats, 0);
    if (arp_req_ready !== 1'b1) report_mismatch("arp_req_ready", arp_req_ready, 1'b1);
    if (set_ip_ready !== 1'b1) report_mismatch("set_ip_ready", set_ip_ready, 1'b1);
    if (set_board_ready !== 1'b1) report_mismatch("set_board_ready", set_board_ready, 1'b1);
    end_test("reset state");

    // One lookup at a time with reprogramming where the entry changes
    for (int i = 0; i < TABLE_LEN; i++) begin
      if (lookup_table[i].ip != cur_ip.word || lookup_table[i].board != cur_board) begin
        write_config(lookup_table[i].ip, lookup_table[i].board);
      end
      run_traffic(i, 1, 1'b1, 1'b0, 1'b0);
    end
    end_test("table lookup and board rewrite");

    run_traffic(0, TABLE_LEN, 1'b0, 1'b0, 1'b1);
    end_test("back-to-back latency");

    run_traffic(0, TABLE_LEN, 1'b0, 1'b1, 1'b0);
    end_test("random back-pressure ordering");

    // Let the counters ripple out while no further reply may appear
    repeat (N + 2) begin
      @(negedge aclk);
      if (arp_rsp_valid !== 1'b0) begin
        report_mismatch("arp_rsp_valid", arp_rsp_valid, 1'b0);
      end
    end
    if (net_stats.request_count !== sent_requests[15:0]) begin
      report_mismatch("net_stats.request_count", net_stats.request_count, sent_requests);
    end
    if (net_stats.hit_count !== sent_hits[15:0]) begin
      report_mismatch("net_stats.hit_count", net_stats.hit_count, sent_hits);
    end
    if (net_stats.miss_count !== sent_misses[15:0]) begin
      report_mismatch("net_stats.miss_count", net_stats.miss_count, sent_misses);
    end
    end_test("statistics");

    $display("Tests run: %0d, errors: %0d", tests_run, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/network_ctrl_sva.sv
/*
 * Handshake assertions for the control path top level.
 * Bound onto network_ctrl_top from the testbench.
 */
`timescale 1ns/1ps
`default_nettype none

module network_ctrl_sva
  import net_types_pkg::*;
(
  input logic         aclk,
  input logic         reset,
  input logic         arp_req_valid,
  input logic         arp_req_ready,
  input arp_request_t arp_req_data,
  input logic         arp_rsp_valid,
  input logic         arp_rsp_ready,
  input arp_reply_t   arp_rsp_data,
  input logic         set_ip_valid,
  input logic         set_ip_ready,
  input ip_addr_t     set_ip_data,
  input logic         set_board_valid,
  input logic         set_board_ready,
  input board_num_t   set_board_data
);

  // Number of assertion failures so far
  int failures = 0;

  // Reply held with stable data until taken
  rsp_hold: assert property (@(posedge aclk) disable iff (reset)
    arp_rsp_valid && !arp_rsp_ready |=> arp_rsp_valid && $stable(arp_rsp_data))
    else begin
      $error("arp_rsp_valid dropped or data changed before transfer");
      failures++;
    end

  // Same rule on the user-driven channels
  req_hold: assert property (@(posedge aclk) disable iff (reset)
    arp_req_valid && !arp_req_ready |=> arp_req_valid && $stable(arp_req_data))
    else begin
      $error("arp_req_valid dropped or data changed before transfer");
      failures++;
    end

  ip_hold: assert property (@(posedge aclk) disable iff (reset)
    set_ip_valid && !set_ip_ready |=> set_ip_valid && $stable(set_ip_data))
    else begin
      $error("set_ip_valid dropped or data changed before transfer");
      failures++;
    end

  board_hold: assert property (@(posedge aclk) disable iff (reset)
    set_board_valid && !set_board_ready |=> set_board_valid && $stable(set_board_data))
    else begin
      $error("set_board_valid dropped or data changed before transfer");
      failures++;
    end

  // Quiet channels while reset is applied
  rsp_reset: assert property (@(posedge aclk) reset |=> !arp_rsp_valid)
    else begin
      $error("arp_rsp_valid high during reset");
      failures++;
    end

  in_reset: assert property (@(posedge aclk)
    reset |-> !arp_req_valid && !set_ip_valid && !set_board_valid)
    else begin
      $error("input valid high during reset");
      failures++;
    end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
/*
 * Clock and reset source for the control path testbench.
 * Free-running clock, reset held high for a fixed number of cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic aclk,
  output logic reset
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Release on a falling edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: source/network_ctrl_top.sv
/*
 * Control path top level with plain ports.
 * User ports cross the slice array into the ARP responder.
 */
`timescale 1ns/1ps
`default_nettype none

module network_ctrl_top
  import net_types_pkg::*, net_stat_pkg::*;
(
  input  logic         aclk,
  input  logic         reset,
  input  logic         arp_req_valid,
  output logic         arp_req_ready,
  input  arp_request_t arp_req_data,
  output logic         arp_rsp_valid,
  input  logic         arp_rsp_ready,
  output arp_reply_t   arp_rsp_data,
  input  logic         set_ip_valid,
  output logic         set_ip_ready,
  input  ip_addr_t     set_ip_data,
  input  logic         set_board_valid,
  output logic         set_board_ready,
  input  board_num_t   set_board_data,
  output net_stat_t    net_stats
);

  // User side of the slices, and slices to responder
  net_ctrl_if user_if ();
  net_ctrl_if net_if ();

  assign user_if.arp_req_valid   = arp_req_valid;
  assign user_if.arp_req_data    = arp_req_data;
  assign arp_req_ready           = user_if.arp_req_ready;
  assign arp_rsp_valid           = user_if.arp_rsp_valid;
  assign arp_rsp_data            = user_if.arp_rsp_data;
  assign user_if.arp_rsp_ready   = arp_rsp_ready;
  assign user_if.set_ip_valid    = set_ip_valid;
  assign user_if.set_ip_data     = set_ip_data;
  assign set_ip_ready            = user_if.set_ip_ready;
  assign user_if.set_board_valid = set_board_valid;
  assign user_if.set_board_data  = set_board_data;
  assign set_board_ready         = user_if.set_board_ready;
  assign net_stats               = user_if.net_stats;

  network_slice_array network_slice_array_inst (
    .aclk(aclk),
    .reset(reset),
    .user_side(user_if.net),
    .net_side(net_if.user)
  );

  arp_responder arp_responder_inst (
    .aclk(aclk),
    .reset(reset),
    .ctrl(net_if.net)
  );

endmodule

`default_nettype wire

// File: source/arp_responder.sv
/*
 * Network-side ARP model for the control path.
 * Holds local IP and board number, answers lookups by subnet match, counts traffic.
 */
`timescale 1ns/1ps
`include "net_config.svh"
`default_nettype none

module arp_responder
  import net_types_pkg::*, net_stat_pkg::*;
(
  input  logic   aclk,
  input  logic   reset,
  net_ctrl_if.net ctrl
);

  // Address configuration
  ip_addr_t   local_ip;
  board_num_t board_num;

  // Single reply register
  logic       rsp_valid_q;
  arp_reply_t rsp_q;

  net_stat_t  stats_q;

  logic       req_fire;
  logic       lookup_hit;
  arp_reply_t rsp_next;

  // Settings are never back-pressured
  assign ctrl.set_ip_ready    = 1'b1;
  assign ctrl.set_board_ready = 1'b1;

  // Accept when reply slot empty or draining this cycle
  assign ctrl.arp_req_ready = !rsp_valid_q || ctrl.arp_rsp_ready;
  assign req_fire = ctrl.arp_req_valid && ctrl.arp_req_ready;

  // Same /24 as the local address
  assign lookup_hit = ctrl.arp_req_data.target.octets[3:1] == local_ip.octets[3:1];

  always_comb begin
    rsp_next.hit    = lookup_hit;
    rsp_next.target = ctrl.arp_req_data.target;
    if (lookup_hit) begin
      // OUI, board, then host part of the target
      rsp_next.mac = {`NET_MAC_OUI, board_num, ctrl.arp_req_data.target.octets[1:0]};
    end else begin
      rsp_next.mac = '0;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      local_ip.word <= '0;
      board_num     <= '0;
    end else begin
      if (ctrl.set_ip_valid) begin
        local_ip <= ctrl.set_ip_data;
      end
      if (ctrl.set_board_valid) begin
        board_num <= ctrl.set_board_data;
      end
    end
  end

  // Reply valid
  always_ff @(posedge aclk) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (ctrl.arp_rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (req_fire) begin
      rsp_q <= rsp_next;
    end
  end

  // Counters wrap silently
  always_ff @(posedge aclk) begin
    if (reset) begin
      stats_q <= '0;
    end else if (req_fire) begin
      stats_q.request_count <= stats_q.request_count + 1'b1;
      if (lookup_hit) begin
        stats_q.hit_count <= stats_q.hit_count + 1'b1;
      end else begin
        stats_q.miss_count <= stats_q.miss_count + 1'b1;
      end
    end
  end

  assign ctrl.arp_rsp_valid = rsp_valid_q;
  assign ctrl.arp_rsp_data  = rsp_q;
  assign ctrl.net_stats     = stats_q;

endmodule

`default_nettype wire

// File: source/network_slice_array.sv
/*
 * Register slice chain between user region and network stack.
 * Every channel crosses NET_N_STAGES slices; statistics ride a plain register chain.
 */
`timescale 1ns/1ps
`include "net_config.svh"
`default_nettype none

module network_slice_array
  import net_types_pkg::*, net_stat_pkg::*;
(
  input  logic   aclk,
  input  logic   reset,
  net_ctrl_if.net  user_side,
  net_ctrl_if.user net_side
);

  localparam int N = `NET_N_STAGES;

  // Stage 0 is where a channel enters, stage N where it leaves
  logic         req_valid [N+1];
  logic         req_ready [N+1];
  arp_request_t req_data  [N+1];

  logic         rsp_valid [N+1];
  logic         rsp_ready [N+1];
  arp_reply_t   rsp_data  [N+1];

  logic         ip_valid [N+1];
  logic         ip_ready [N+1];
  ip_addr_t     ip_data  [N+1];

  logic         board_valid [N+1];
  logic         board_ready [N+1];
  board_num_t   board_data  [N+1];

  wire net_stat_t stat_pipe [N+1];

  // Requests and settings enter from the user side
  assign req_valid[0]        = user_side.arp_req_valid;
  assign req_data[0]         = user_side.arp_req_data;
  assign user_side.arp_req_ready = req_ready[0];

  assign ip_valid[0]         = user_side.set_ip_valid;
  assign ip_data[0]          = user_side.set_ip_data;
  assign user_side.set_ip_ready = ip_ready[0];

  assign board_valid[0]      = user_side.set_board_valid;
  assign board_data[0]       = user_side.set_board_data;
  assign user_side.set_board_ready = board_ready[0];

  // and leave on the network side
  assign net_side.arp_req_valid = req_valid[N];
  assign net_side.arp_req_data  = req_data[N];
  assign req_ready[N]           = net_side.arp_req_ready;

  assign net_side.set_ip_valid  = ip_valid[N];
  assign net_side.set_ip_data   = ip_data[N];
  assign ip_ready[N]            = net_side.set_ip_ready;

  assign net_side.set_board_valid = board_valid[N];
  assign net_side.set_board_data  = board_data[N];
  assign board_ready[N]           = net_side.set_board_ready;

  // Replies and statistics run the other way
  assign rsp_valid[0]           = net_side.arp_rsp_valid;
  assign rsp_data[0]            = net_side.arp_rsp_data;
  assign net_side.arp_rsp_ready = rsp_ready[0];

  assign user_side.arp_rsp_valid = rsp_valid[N];
  assign user_side.arp_rsp_data  = rsp_data[N];
  assign rsp_ready[N]            = user_side.arp_rsp_ready;

  assign stat_pipe[0]        = net_side.net_stats;
  assign user_side.net_stats = stat_pipe[N];

  for (genvar i = 0; i < N; i++) begin : stage
    net_stat_t stat_q;

    reg_slice #(.WIDTH($bits(arp_request_t))) arp_req_slice_inst (
      .aclk(aclk), .reset(reset),
      .in_valid(req_valid[i]), .in_ready(req_ready[i]), .in_data(req_data[i]),
      .out_valid(req_valid[i+1]), .out_ready(req_ready[i+1]), .out_data(req_data[i+1])
    );

    reg_slice #(.WIDTH($bits(arp_reply_t))) arp_rsp_slice_inst (
      .aclk(aclk), .reset(reset),
      .in_valid(rsp_valid[i]), .in_ready(rsp_ready[i]), .in_data(rsp_data[i]),
      .out_valid(rsp_valid[i+1]), .out_ready(rsp_ready[i+1]), .out_data(rsp_data[i+1])
    );

    reg_slice #(.WIDTH($bits(ip_addr_t))) set_ip_slice_inst (
      .aclk(aclk), .reset(reset),
      .in_valid(ip_valid[i]), .in_ready(ip_ready[i]), .in_data(ip_data[i]),
      .out_valid(ip_valid[i+1]), .out_ready(ip_ready[i+1]), .out_data(ip_data[i+1])
    );

    reg_slice #(.WIDTH($bits(board_num_t))) set_board_slice_inst (
      .aclk(aclk), .reset(reset),
      .in_valid(board_valid[i]), .in_ready(board_ready[i]), .in_data(board_data[i]),
      .out_valid(board_valid[i+1]), .out_ready(board_ready[i+1]),
      .out_data(board_data[i+1])
    );

    // Stats always move, zero out of reset
    always_ff @(posedge aclk) begin
      if (reset) begin
        stat_q <= '0;
      end else begin
        stat_q <= stat_pipe[i];
      end
    end

    assign stat_pipe[i+1] = stat_q;
  end

endmodule

`default_nettype wire

// File: source/reg_slice.sv
/*
 * Valid/ready register slice with a skid entry.
 * One cycle latency, full throughput, ready comes straight from a flop.
 */
`timescale 1ns/1ps
`default_nettype none

module reg_slice #(
  parameter int WIDTH = 32
) (
  input  logic             aclk,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // Main entry drives the output
  logic             main_valid;
  logic [WIDTH-1:0] main_data;

  // Skid entry catches the item accepted while the output stalls
  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;

  logic main_free;

  // Main can take a new item when empty or being drained
  assign main_free = out_ready || !main_valid;

  // Only a full skid entry blocks the input
  assign in_ready = !skid_valid;

  always_ff @(posedge aclk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      if (skid_valid) begin
        // Drain skid first, input is blocked this cycle
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= in_valid;
      end
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  // Payload path, no reset
  always_ff @(posedge aclk) begin
    if (main_free) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (in_valid) begin
        main_data <= in_data;
      end
    end else if (in_valid && in_ready) begin
      skid_data <= in_data;
    end
  end

  assign out_valid = main_valid;
  assign out_data  = main_data;

endmodule

`default_nettype wire

// File: source/net_ctrl_if.sv
/*
 * Control channels between user region and network stack.
 * User modport sends requests and settings, net modport answers.
 */
`timescale 1ns/1ps
`default_nettype none

interface net_ctrl_if
  import net_types_pkg::*, net_stat_pkg::*;
  ();

  // ARP lookup, user to network
  logic arp_req_valid;
  logic arp_req_ready;
  arp_request_t arp_req_data;

  // ARP reply, network to user
  logic arp_rsp_valid;
  logic arp_rsp_ready;
  arp_reply_t arp_rsp_data;

  // Local IP setting
  logic set_ip_valid;
  logic set_ip_ready;
  ip_addr_t set_ip_data;

  // Board number setting
  logic set_board_valid;
  logic set_board_ready;
  board_num_t set_board_data;

  // Free-running, no handshake
  net_stat_t net_stats;

  modport user (
    output arp_req_valid, arp_req_data, input arp_req_ready,
    input arp_rsp_valid, arp_rsp_data, output arp_rsp_ready,
    output set_ip_valid, set_ip_data, input set_ip_ready,
    output set_board_valid, set_board_data, input set_board_ready,
    input net_stats
  );

  modport net (
    input arp_req_valid, arp_req_data, output arp_req_ready,
    output arp_rsp_valid, arp_rsp_data, input arp_rsp_ready,
    input set_ip_valid, set_ip_data, output set_ip_ready,
    input set_board_valid, set_board_data, output set_board_ready,
    output net_stats
  );

endinterface

`default_nettype wire

// File: source/net_stat_pkg.sv
/*
 * Statistics word reported by the network side.
 * Three wrapping counters packed into one word.
 */
`include "net_config.svh"
`default_nettype none

package net_stat_pkg;

  typedef logic [`NET_STAT_BITS-1:0] stat_cnt_t;

  // Request count sits in the top bits
  typedef struct packed {
    stat_cnt_t request_count;
    stat_cnt_t hit_count;
    stat_cnt_t miss_count;
  } net_stat_t;

endpackage

`default_nettype wire

// File: source/net_types_pkg.sv
/*
 * ARP and addressing types shared by the control path.
 * Import where requests, replies or addresses are handled.
 */
`include "net_config.svh"
`default_nettype none

package net_types_pkg;

  // One IP address, seen as a word or as four octets
  // Octet 3 is the first octet in dotted notation
  typedef union packed {
    logic [`NET_IP_BITS-1:0] word;
    logic [`NET_IP_BITS/8-1:0][7:0] octets;
  } ip_addr_t;

  typedef logic [`NET_MAC_BITS-1:0] mac_addr_t;

  typedef logic [`NET_BOARD_BITS-1:0] board_num_t;

  // Lookup request carries only the target
  typedef struct packed {
    ip_addr_t target;
  } arp_request_t;

  // Reply echoes the target so it can be paired with its request
  typedef struct packed {
    logic hit;
    mac_addr_t mac;
    ip_addr_t target;
  } arp_reply_t;

endpackage

`default_nettype wire

// File: source/net_config.svh
/*
 * Build-time constants for the network control path.
 * Included by packages and modules that need stage count, widths or the MAC prefix.
 */
`ifndef NET_CONFIG_SVH
`define NET_CONFIG_SVH

`default_nettype none

// Register slice depth per channel
`define NET_N_STAGES 2

// Address and identifier widths
`define NET_IP_BITS 32
`define NET_BOARD_BITS 8
`define NET_MAC_BITS 48

// Locally administered prefix for generated MACs
`define NET_MAC_OUI 24'h02_1a_4e

// Each statistics counter
`define NET_STAT_BITS 16

`default_nettype wire

`endif
